// ==== rtl/ahb_lite_pkg.sv ====
// AHB-Lite bus types and codes, imported by every bus-facing module of the monitor
`default_nettype none

package ahb_lite_pkg;

    // --------------------
    // Bus widths

    // Byte address driven by the master
    typedef logic [31:0] haddr_t;

    // Read and write data word
    typedef logic [31:0] hdata_t;

    // --------------------
    // Transfer types

    // HTRANS encoding, also used as the data-phase state of the slave
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } trans_t;

    // --------------------
    // Responses

    typedef logic [1:0] hresp_t;

    // Only response the slave ever gives
    localparam hresp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== rtl/pmu_cfg_pkg.sv ====
// Register map and field positions of the event monitor, shared by the bank, core and bus port
`default_nettype none

package pmu_cfg_pkg;

    // --------------------
    // Register word

    // Every slave register is one bus word wide
    typedef logic [31:0] reg_word_t;

    // --------------------
    // Register map

    // Main configuration register
    localparam int CFG_IDX = 0;

    // First counter, counter i sits at CNT_BASE + i
    localparam int CNT_BASE = 1;

    // Status and interrupt enable follow the last counter
    // Their index is N_COUNTERS plus these offsets
    localparam int OVF_STATUS_OFS = 1;
    localparam int OVF_IRQEN_OFS  = 2;

    // Registers besides the counters: config, status, irq enable
    localparam int N_FIXED_REGS = 3;

    // --------------------
    // Configuration fields

    // Counting runs while set
    localparam int CFG_EN_BIT = 0;

    // Holds counters and overflow status at zero while set
    localparam int CFG_SOFTRST_BIT = 1;

    // Returned for reads outside the map or outside a read data phase
    localparam reg_word_t INVALID_READ_WORD = 32'hCAFE_1D1E;

endpackage

`default_nettype wire

// ==== rtl/ahb_slave_port.sv ====
// AHB-Lite slave port: registers the address phase and serves the monitor registers
`default_nettype none

module ahb_slave_port #(
    parameter int  N_COUNTERS = 4,
    localparam int N_REGS     = N_COUNTERS + pmu_cfg_pkg::N_FIXED_REGS,
    localparam int IDX_W      = $clog2(N_REGS)
) (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    // AHB-Lite slave side
    input  wire                         hsel_i,
    input  wire ahb_lite_pkg::trans_t   htrans_i,
    input  wire ahb_lite_pkg::haddr_t   haddr_i,
    input  wire                         hwrite_i,
    input  wire ahb_lite_pkg::hdata_t   hwdata_i,
    output logic                        hreadyo_o,
    output ahb_lite_pkg::hresp_t        hresp_o,
    output ahb_lite_pkg::hdata_t        hrdata_o,
    // Register bank side
    input  wire pmu_cfg_pkg::reg_word_t regs_i [N_REGS],
    output logic                        wr_en_o,
    output logic [IDX_W-1:0]            wr_idx_o,
    output pmu_cfg_pkg::reg_word_t      wr_data_o
);
    import ahb_lite_pkg::*;
    import pmu_cfg_pkg::*;

    // Transfer type of the data phase in progress
    trans_t state_q;
    trans_t state_d;

    // Address phase captured for the data phase
    haddr_t addr_q;
    logic   write_q;

    logic             capture;
    logic             data_phase;
    logic             idx_valid;
    logic [IDX_W-1:0] idx;

    // --------------------
    // Address phase

    // Deselected slave sees an idle bus
    always_comb begin
        if (hsel_i) begin
            state_d = htrans_i;
        end else begin
            state_d = IDLE;
        end
    end

    // Only real transfers carry an address worth keeping
    assign capture = (state_d == NONSEQ) || (state_d == SEQ);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // IDLE and BUSY never write
            write_q <= capture ? hwrite_i : 1'b0;
        end
    end

    // Address holds through IDLE and BUSY
    always_ff @(posedge clk_i) begin
        if (capture) begin
            addr_q <= haddr_i;
        end
    end

    // --------------------
    // Data phase

    assign data_phase = (state_q == NONSEQ) || (state_q == SEQ);

    // Word index, byte lanes dropped
    assign idx = addr_q[IDX_W+1:2];

    // Whole word address is checked so higher addresses do not alias
    assign idx_valid = addr_q[$bits(haddr_t)-1:2] < N_REGS;

    // Write request to the bank, already qualified
    assign wr_en_o   = data_phase && write_q && idx_valid;
    assign wr_idx_o  = idx;
    assign wr_data_o = hwdata_i;

    // Read data straight from the bank in the data phase
    always_comb begin
        if (data_phase && !write_q && idx_valid) begin
            hrdata_o = regs_i[idx];
        end else begin
            hrdata_o = INVALID_READ_WORD;
        end
    end

    // No wait states, no error responses
    assign hreadyo_o = 1'b1;
    assign hresp_o   = RESP_OKAY;

endmodule

`default_nettype wire

// ==== rtl/pmu_reg_bank.sv ====
// Slave register bank of the monitor: loads core updates each cycle, bus writes take priority
`default_nettype none

module pmu_reg_bank #(
    parameter int  N_COUNTERS = 4,
    localparam int N_REGS     = N_COUNTERS + pmu_cfg_pkg::N_FIXED_REGS,
    localparam int IDX_W      = $clog2(N_REGS)
) (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    // Bus write from the slave port, index already checked
    input  wire                         wr_en_i,
    input  wire [IDX_W-1:0]             wr_idx_i,
    input  wire pmu_cfg_pkg::reg_word_t wr_data_i,
    // Values computed by the counter core
    input  wire pmu_cfg_pkg::reg_word_t next_regs_i [N_REGS],
    // Current register contents
    output pmu_cfg_pkg::reg_word_t      regs_o [N_REGS]
);
    import pmu_cfg_pkg::*;

    reg_word_t regs_d [N_REGS];
    reg_word_t regs_q [N_REGS];

    // --------------------
    // Next contents

    // Core value by default
    // A bus write replaces only its own register
    always_comb begin
        for (int i = 0; i < N_REGS; i++) begin
            if (wr_en_i && (wr_idx_i == i)) begin
                regs_d[i] = wr_data_i;
            end else begin
                regs_d[i] = next_regs_i[i];
            end
        end
    end

    // --------------------
    // Storage

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            regs_q <= regs_d;
        end
    end

    // Same array feeds the bus port and the core
    assign regs_o = regs_q;

endmodule

`default_nettype wire

// ==== rtl/pmu_counters.sv ====
// Event counter core: computes next counter, status and pass-through values from the registers
`default_nettype none

module pmu_counters #(
    parameter int  N_COUNTERS = 4,
    localparam int N_REGS     = N_COUNTERS + pmu_cfg_pkg::N_FIXED_REGS
) (
    // Current register contents from the bank
    input  wire pmu_cfg_pkg::reg_word_t regs_i [N_REGS],
    // One event line per counter
    input  wire [N_COUNTERS-1:0]        events_i,
    // Values the bank loads at the next edge
    output pmu_cfg_pkg::reg_word_t      next_regs_o [N_REGS],
    output logic                        intr_overflow_o
);
    import pmu_cfg_pkg::*;

    localparam int STATUS_IDX = N_COUNTERS + OVF_STATUS_OFS;
    localparam int IRQEN_IDX  = N_COUNTERS + OVF_IRQEN_OFS;

    logic                  count_en;
    logic                  soft_rst;
    logic [N_COUNTERS-1:0] wrap;
    logic [N_COUNTERS-1:0] ovf_status;
    logic [N_COUNTERS-1:0] ovf_irq_en;

    // --------------------
    // Configuration fields

    assign count_en = regs_i[CFG_IDX][CFG_EN_BIT];
    assign soft_rst = regs_i[CFG_IDX][CFG_SOFTRST_BIT];

    // Only the low N_COUNTERS bits mean anything
    assign ovf_status = regs_i[STATUS_IDX][N_COUNTERS-1:0];
    assign ovf_irq_en = regs_i[IRQEN_IDX][N_COUNTERS-1:0];

    // Counter at all-ones about to count once more
    always_comb begin
        for (int i = 0; i < N_COUNTERS; i++) begin
            wrap[i] = count_en && events_i[i] && (&regs_i[CNT_BASE + i]);
        end
    end

    // --------------------
    // Next values

    always_comb begin
        // Config and irq enable keep their contents
        next_regs_o = regs_i;

        for (int i = 0; i < N_COUNTERS; i++) begin
            if (soft_rst) begin
                next_regs_o[CNT_BASE + i] = '0;
            end else if (count_en && events_i[i]) begin
                // Wraps to zero after all-ones
                next_regs_o[CNT_BASE + i] = regs_i[CNT_BASE + i] + 1'b1;
            end
        end

        // Status bits are sticky until soft reset or a bus write
        if (soft_rst) begin
            next_regs_o[STATUS_IDX] = '0;
        end else begin
            next_regs_o[STATUS_IDX][N_COUNTERS-1:0] = ovf_status | wrap;
        end
    end

    // Registered status gated by the enable mask
    assign intr_overflow_o = |(ovf_status & ovf_irq_en);

endmodule

`default_nettype wire

// ==== rtl/pmu_ahb.sv ====
// Top level of the AHB-Lite event monitor: connects bus port, register bank and counter core
`default_nettype none

module pmu_ahb #(
    parameter int N_COUNTERS = 4
) (
    input  wire                       clk_i,
    input  wire                       rstn_i,
    // AHB-Lite slave
    input  wire                       hsel_i,
    input  wire ahb_lite_pkg::trans_t htrans_i,
    input  wire ahb_lite_pkg::haddr_t haddr_i,
    input  wire                       hwrite_i,
    input  wire ahb_lite_pkg::hdata_t hwdata_i,
    output logic                      hreadyo_o,
    output ahb_lite_pkg::hresp_t      hresp_o,
    output ahb_lite_pkg::hdata_t      hrdata_o,
    // Monitored events and interrupt
    input  wire [N_COUNTERS-1:0]      events_i,
    output logic                      intr_overflow_o
);
    import pmu_cfg_pkg::*;

    localparam int N_REGS = N_COUNTERS + N_FIXED_REGS;
    localparam int IDX_W  = $clog2(N_REGS);

    // --------------------
    // Internal nets

    reg_word_t        regs [N_REGS];
    reg_word_t        next_regs [N_REGS];
    logic             wr_en;
    logic [IDX_W-1:0] wr_idx;
    reg_word_t        wr_data;

    // Bus pipeline and read mux
    ahb_slave_port #(
        .N_COUNTERS (N_COUNTERS)
    ) port_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .hsel_i    (hsel_i),
        .htrans_i  (htrans_i),
        .haddr_i   (haddr_i),
        .hwrite_i  (hwrite_i),
        .hwdata_i  (hwdata_i),
        .hreadyo_o (hreadyo_o),
        .hresp_o   (hresp_o),
        .hrdata_o  (hrdata_o),
        .regs_i    (regs),
        .wr_en_o   (wr_en),
        .wr_idx_o  (wr_idx),
        .wr_data_o (wr_data)
    );

    // Register storage
    pmu_reg_bank #(
        .N_COUNTERS (N_COUNTERS)
    ) bank_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .wr_en_i     (wr_en),
        .wr_idx_i    (wr_idx),
        .wr_data_i   (wr_data),
        .next_regs_i (next_regs),
        .regs_o      (regs)
    );

    // Counting and overflow logic
    pmu_counters #(
        .N_COUNTERS (N_COUNTERS)
    ) core_i (
        .regs_i          (regs),
        .events_i        (events_i),
        .next_regs_o     (next_regs),
        .intr_overflow_o (intr_overflow_o)
    );

endmodule

`default_nettype wire

// ==== test/pmu_ahb_assertions.sv ====
// Concurrent checks on bus response, interrupt and config writes, bound into the monitor top
`default_nettype none

module pmu_ahb_assertions #(
    parameter int  N_COUNTERS = 4,
    localparam int N_REGS     = N_COUNTERS + pmu_cfg_pkg::N_FIXED_REGS,
    localparam int IDX_W      = $clog2(N_REGS)
) (
    input wire                         clk_i,
    input wire                         rstn_i,
    input wire                         hreadyo_i,
    input wire ahb_lite_pkg::hresp_t   hresp_i,
    input wire                         intr_overflow_i,
    input wire                         wr_en_i,
    input wire [IDX_W-1:0]             wr_idx_i,
    input wire pmu_cfg_pkg::reg_word_t cfg_i,
    input wire pmu_cfg_pkg::reg_word_t status_i,
    input wire pmu_cfg_pkg::reg_word_t irqen_i
);
    import ahb_lite_pkg::*;
    import pmu_cfg_pkg::*;

    // Failed assertions, summed up by the testbench
    int fail_count = 0;

    // No wait states and no error responses
    resp_okay: assert property (@(posedge clk_i) hreadyo_i && (hresp_i == RESP_OKAY))
        else begin
            $error("slave inserted a wait state or gave a non-OKAY response");
            fail_count++;
        end

    // Interrupt only from an enabled status bit
    intr_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
        intr_overflow_i |-> |(status_i[N_COUNTERS-1:0] & irqen_i[N_COUNTERS-1:0]))
        else begin
            $error("overflow interrupt without an enabled status bit");
            fail_count++;
        end

    // Config is written only by the bus
    cfg_write_only: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $changed(cfg_i) |-> $past(wr_en_i && (wr_idx_i == CFG_IDX)))
        else begin
            $error("config register changed without a bus write to index 0");
            fail_count++;
        end

endmodule

bind pmu_ahb pmu_ahb_assertions #(
    .N_COUNTERS (N_COUNTERS)
) assertions_i (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .hreadyo_i       (hreadyo_o),
    .hresp_i         (hresp_o),
    .intr_overflow_i (intr_overflow_o),
    .wr_en_i         (wr_en),
    .wr_idx_i        (wr_idx),
    .cfg_i           (regs[pmu_cfg_pkg::CFG_IDX]),
    .status_i        (regs[N_COUNTERS + pmu_cfg_pkg::OVF_STATUS_OFS]),
    .irqen_i         (regs[N_COUNTERS + pmu_cfg_pkg::OVF_IRQEN_OFS])
);

`default_nettype wire

// ==== test/pmu_ahb_tb.sv ====
// Self-checking testbench of the AHB-Lite event monitor, compiled with the files in sources.f
`default_nettype none

module pmu_ahb_tb;
    import ahb_lite_pkg::*;
    import pmu_cfg_pkg::*;

    localparam int N_COUNTERS   = 4;
    localparam int N_REGS       = N_COUNTERS + N_FIXED_REGS;
    localparam int STATUS_IDX   = N_COUNTERS + OVF_STATUS_OFS;
    localparam int IRQEN_IDX    = N_COUNTERS + OVF_IRQEN_OFS;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;

    // Cycle budget per test, each bus transfer takes two cycles
    localparam int TEST_CYCLES     = 16 + 16 + 88 + 16 + 28 + 24;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 50;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  hsel_i;
    trans_t                htrans_i;
    haddr_t                haddr_i;
    logic                  hwrite_i;
    hdata_t                hwdata_i;
    logic                  hreadyo_o;
    hresp_t                hresp_o;
    hdata_t                hrdata_o;
    logic [N_COUNTERS-1:0] events_i;
    logic                  intr_overflow_o;

    // Expected register contents
    reg_word_t   model [N_REGS];
    logic [31:0] rng;
    int          n_checks;
    int          n_errors;
    int          err_mark;

    pmu_ahb #(
        .N_COUNTERS (N_COUNTERS)
    ) dut_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .hsel_i          (hsel_i),
        .htrans_i        (htrans_i),
        .haddr_i         (haddr_i),
        .hwrite_i        (hwrite_i),
        .hwdata_i        (hwdata_i),
        .hreadyo_o       (hreadyo_o),
        .hresp_o         (hresp_o),
        .hrdata_o        (hrdata_o),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Single NONSEQ write, returns in its data phase
    task automatic bus_write(input haddr_t addr, input hdata_t data);
        int unsigned idx;
        idx = addr >> 2;
        @(negedge clk_i);
        hsel_i   = 1'b1;
        htrans_i = NONSEQ;
        haddr_i  = addr;
        hwrite_i = 1'b1;
        @(negedge clk_i);
        hsel_i   = 1'b0;
        htrans_i = IDLE;
        hwrite_i = 1'b0;
        hwdata_i = data;
        // Writes outside the map change nothing
        if (idx < N_REGS) begin
            model[idx] = data;
        end
        // Soft reset clears counters and status on the following edge
        if (idx == CFG_IDX && data[CFG_SOFTRST_BIT]) begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                model[CNT_BASE + i] = '0;
            end
            model[STATUS_IDX] = '0;
        end
    endtask

    // Single NONSEQ read, data sampled mid data phase
    task automatic bus_read(input haddr_t addr, output hdata_t data);
        @(negedge clk_i);
        hsel_i   = 1'b1;
        htrans_i = NONSEQ;
        haddr_i  = addr;
        hwrite_i = 1'b0;
        @(negedge clk_i);
        hsel_i   = 1'b0;
        htrans_i = IDLE;
        data     = hrdata_o;
    endtask

    task automatic check_word(input string what, input reg_word_t got, input reg_word_t exp);
        n_checks++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_reg(input int idx);
        hdata_t rd;
        bus_read(haddr_t'(idx << 2), rd);
        check_word($sformatf("register %0d", idx), rd, model[idx]);
    endtask

    task automatic check_intr(input logic exp);
        check_word("overflow interrupt", {31'b0, intr_overflow_o}, {31'b0, exp});
    endtask

    // One cycle of events, counted at the next rising edge while enabled
    task automatic drive_events(input logic [N_COUNTERS-1:0] ev);
        @(negedge clk_i);
        events_i = ev;
        if (model[CFG_IDX][CFG_EN_BIT] && !model[CFG_IDX][CFG_SOFTRST_BIT]) begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                if (ev[i]) begin
                    // Wrap from all-ones sets the sticky status bit
                    if (&model[CNT_BASE + i]) begin
                        model[STATUS_IDX][i] = 1'b1;
                    end
                    model[CNT_BASE + i] = model[CNT_BASE + i] + 1;
                end
            end
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %-12s %s", name, (n_errors == err_mark) ? "passed" : "FAILED");
        err_mark = n_errors;
    endtask

    // --------------------
    // Tests

    initial begin
        hdata_t rd;
        clk_i    = 1'b0;
        rstn_i   = 1'b0;
        hsel_i   = 1'b0;
        htrans_i = IDLE;
        haddr_i  = '0;
        hwrite_i = 1'b0;
        hwdata_i = '0;
        events_i = '0;
        rng      = 32'd57;
        n_checks = 0;
        n_errors = 0;
        err_mark = 0;
        for (int i = 0; i < N_REGS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;

        // Reset values
        for (int i = 0; i < N_REGS; i++) begin
            check_reg(i);
        end
        check_intr(1'b0);
        finish_test("reset");

        // Write and read-back, counter written with counting off
        rng = xorshift32(rng);
        bus_write(CFG_IDX << 2, rng);
        check_reg(CFG_IDX);
        rng = xorshift32(rng);
        bus_write(IRQEN_IDX << 2, rng);
        check_reg(IRQEN_IDX);
        bus_write(CFG_IDX << 2, '0);
        rng = xorshift32(rng);
        bus_write(CNT_BASE << 2, rng);
        check_reg(CNT_BASE);
        finish_test("write_read");

        // Counting of random events
        bus_write(CNT_BASE << 2, '0);
        bus_write(CFG_IDX << 2, 32'h1 << CFG_EN_BIT);
        repeat (2) @(negedge clk_i);
        for (int c = 0; c < 64; c++) begin
            rng = xorshift32(rng);
            drive_events(rng[N_COUNTERS-1:0]);
        end
        drive_events('0);
        repeat (2) @(negedge clk_i);
        bus_write(CFG_IDX << 2, '0);
        for (int i = 0; i < N_COUNTERS; i++) begin
            check_reg(CNT_BASE + i);
        end
        finish_test("counting");

        // Soft reset pulse, status filled first so its clearing shows
        bus_write(STATUS_IDX << 2, '1);
        bus_write(CFG_IDX << 2, 32'h1 << CFG_SOFTRST_BIT);
        bus_write(CFG_IDX << 2, '0);
        for (int i = 0; i < N_COUNTERS; i++) begin
            check_reg(CNT_BASE + i);
        end
        check_reg(STATUS_IDX);
        finish_test("soft_reset");

        // Counter 2 wraps after four events
        bus_write(IRQEN_IDX << 2, '0);
        bus_write((CNT_BASE + 2) << 2, 32'hFFFF_FFFC);
        bus_write(CFG_IDX << 2, 32'h1 << CFG_EN_BIT);
        repeat (4) begin
            drive_events(N_COUNTERS'(4));
        end
        drive_events('0);
        bus_write(CFG_IDX << 2, '0);
        check_reg(CNT_BASE + 2);
        check_reg(STATUS_IDX);
        check_intr(1'b0);
        bus_write(IRQEN_IDX << 2, 32'h1 << 2);
        @(negedge clk_i);
        check_intr(1'b1);
        bus_write(STATUS_IDX << 2, '0);
        @(negedge clk_i);
        check_intr(1'b0);
        finish_test("overflow");

        // Accesses outside the register map
        bus_read(N_REGS << 2, rd);
        check_word("read past last register", rd, INVALID_READ_WORD);
        bus_read(32'h0000_0100, rd);
        check_word("read at high address", rd, INVALID_READ_WORD);
        // High address whose low index bits alias the config register
        rng = xorshift32(rng);
        bus_write(32'h0000_0100, rng);
        for (int i = 0; i < N_REGS; i++) begin
            check_reg(i);
        end
        finish_test("invalid_idx");

        repeat (2) @(negedge clk_i);
        $display("Checks: %0d, failed: %0d, assertion failures: %0d",
                 n_checks, n_errors, dut_i.assertions_i.fail_count);
        if (n_errors == 0 && dut_i.assertions_i.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/ahb_lite_pkg.sv
rtl/pmu_cfg_pkg.sv
rtl/ahb_slave_port.sv
rtl/pmu_reg_bank.sv
rtl/pmu_counters.sv
rtl/pmu_ahb.sv
test/pmu_ahb_assertions.sv
test/pmu_ahb_tb.sv

// ==== Bender.yml ====
package:
  name: pmu_ahb

sources:
  - rtl/ahb_lite_pkg.sv
  - rtl/pmu_cfg_pkg.sv
  - rtl/ahb_slave_port.sv
  - rtl/pmu_reg_bank.sv
  - rtl/pmu_counters.sv
  - rtl/pmu_ahb.sv
  - target: test
    files:
      - test/pmu_ahb_assertions.sv
      - test/pmu_ahb_tb.sv
